//--- include/dual_lane_config.svh
//////////////////////////////////////////////////////////////////////
// word widths, buffer depth and input FIFO sizing for the dual-lane
// store-and-forward buffer; include in every RTL file that sizes a
// port, a pointer or a memory
//////////////////////////////////////////////////////////////////////

`ifndef DUAL_LANE_CONFIG_SVH
`define DUAL_LANE_CONFIG_SVH

// word layout, control byte sits above the data
`define DATA_W 64
`define CTRL_W 8
`define WORD_W (`CTRL_W + `DATA_W)

// per-lane packet buffer
`define BUF_ADDR_W 8
`define BUF_DEPTH (1 << `BUF_ADDR_W)

// input FIFO, nearly full once only the margin is left free
`define FIFO_DEPTH_BITS 2
`define FIFO_DEPTH (1 << `FIFO_DEPTH_BITS)
`define FIFO_NEARLY_FULL_MARGIN 1

`endif

//--- verilog/dual_lane_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared types of the dual-lane buffer: the per-lane packet state
// and the lane select used for the writer and reader grants
//////////////////////////////////////////////////////////////////////

package dual_lane_pkg;

   // packet framing states of one lane
   typedef enum logic [1:0] {
      LANE_START      = 2'b00,
      LANE_PAYLOAD    = 2'b01,
      LANE_READ_READY = 2'b10
   } lane_state_e;

   // which lane holds a grant
   typedef enum logic {
      SEL_LANE0 = 1'b0,
      SEL_LANE1 = 1'b1
   } lane_sel_e;

endpackage

//--- verilog/input_fifo.sv
//////////////////////////////////////////////////////////////////////
// small fall-through FIFO in front of the packet lanes; the head word
// is on dout_o whenever empty_o is low, rd_en_i pops it
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "dual_lane_config.svh"

module input_fifo (
   input  logic                 clk,
   input  logic                 reset,
   input  logic [`WORD_W-1:0]   din_i,
   input  logic                 wr_en_i,
   input  logic                 rd_en_i,
   output logic [`WORD_W-1:0]   dout_o,
   output logic                 empty_o,
   output logic                 nearly_full_o
);

   logic [`WORD_W-1:0]          fifo_mem [0:`FIFO_DEPTH-1];
   logic [`FIFO_DEPTH_BITS-1:0] wr_ptr_q;
   logic [`FIFO_DEPTH_BITS-1:0] rd_ptr_q;
   logic [`FIFO_DEPTH_BITS:0]   count_q;
   logic                        full;
   logic                        push;
   logic                        pop;

   assign full          = (count_q == (`FIFO_DEPTH_BITS+1)'(`FIFO_DEPTH));
   assign empty_o       = (count_q == '0);
   assign nearly_full_o = (count_q >=
                           (`FIFO_DEPTH_BITS+1)'(`FIFO_DEPTH - `FIFO_NEARLY_FULL_MARGIN));

   // overflow and underflow are dropped here
   assign push = wr_en_i && !full;
   assign pop  = rd_en_i && !empty_o;

   // head word visible without a read
   assign dout_o = fifo_mem[rd_ptr_q];

   always_ff @(posedge clk) begin
      if (push) begin
         fifo_mem[wr_ptr_q] <= din_i;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({push, pop})
            2'b10: begin
               count_q <= count_q + 1'b1;
            end
            2'b01: begin
               count_q <= count_q - 1'b1;
            end
            default: begin
               count_q <= count_q;
            end
         endcase
      end
   end

endmodule

//--- verilog/packet_lane.sv
//////////////////////////////////////////////////////////////////////
// one packet lane: framing FSM, 256-word buffer memory and its write
// and read pointers; words are popped from the input FIFO into the
// buffer, then read out one per cycle while the lane holds the
// read grant
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "dual_lane_config.svh"

module packet_lane import dual_lane_pkg::*; (
   input  logic                 clk,
   input  logic                 reset,
   input  logic [`WORD_W-1:0]   word_i,
   input  logic                 fifo_valid_i,
   input  logic                 out_rdy_i,
   input  logic                 read_grant_i,
   output logic                 fifo_rd_o,
   output lane_state_e          state_o,
   output logic                 lane_wr_o,
   output logic [`WORD_W-1:0]   lane_word_o
);

   logic [`WORD_W-1:0]          buf_mem [0:`BUF_DEPTH-1];
   logic [`WORD_W-1:0]          rd_word_q;
   logic [`BUF_ADDR_W-1:0]      wr_ptr_q;
   logic [`BUF_ADDR_W-1:0]      rd_ptr_q;
   lane_state_e                 state_q;
   lane_state_e                 state_d;
   logic                        ctrl_nonzero;
   logic                        in_write_phase;
   logic                        pop;
   logic                        mem_we;
   logic                        ptrs_equal;
   logic                        rd_fire;
   logic                        lane_wr_q;

   //////////////////////////////////////////////////////////////////////
   // write side
   //////////////////////////////////////////////////////////////////////

   assign ctrl_nonzero   = (word_i[`WORD_W-1:`DATA_W] != '0);
   assign in_write_phase = (state_q == LANE_START) || (state_q == LANE_PAYLOAD);

   // pops stall with the downstream ready
   assign pop       = fifo_valid_i && out_rdy_i && in_write_phase;
   assign fifo_rd_o = pop;

   // framing FSM
   always_comb begin
      state_d = state_q;
      mem_we  = 1'b0;
      case (state_q)
         LANE_START: begin
            // zero-control words before a packet start are dropped
            if (pop && ctrl_nonzero) begin
               mem_we  = 1'b1;
               state_d = LANE_PAYLOAD;
            end
         end
         LANE_PAYLOAD: begin
            if (pop) begin
               mem_we = 1'b1;
               if (ctrl_nonzero) begin
                  state_d = LANE_READ_READY;
               end
            end
         end
         LANE_READ_READY: begin
            if (ptrs_equal) begin
               state_d = LANE_START;
            end
         end
         default: begin
            state_d = LANE_START;
         end
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // read side
   //////////////////////////////////////////////////////////////////////

   assign ptrs_equal = (rd_ptr_q == wr_ptr_q);
   assign rd_fire    = read_grant_i && out_rdy_i && !ptrs_equal &&
                       (state_q == LANE_READ_READY);

   // buffer memory, synchronous write and read
   always_ff @(posedge clk) begin
      if (mem_we) begin
         buf_mem[wr_ptr_q] <= word_i;
      end
      rd_word_q <= buf_mem[rd_ptr_q];
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state_q   <= LANE_START;
         wr_ptr_q  <= '0;
         rd_ptr_q  <= '0;
         lane_wr_q <= 1'b0;
      end else begin
         state_q   <= state_d;
         lane_wr_q <= rd_fire;
         if (mem_we) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (rd_fire) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
      end
   end

   // strobe and word line up one cycle after the read decision
   assign state_o     = state_q;
   assign lane_wr_o   = lane_wr_q;
   assign lane_word_o = rd_word_q;

endmodule

//--- verilog/lane_arbiter.sv
//////////////////////////////////////////////////////////////////////
// lane arbiter: hands the write side and the read side from lane to
// lane as each holder finishes its phase, routes the FIFO head and
// strobes to the writer, and merges the lanes' output words
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "dual_lane_config.svh"

module lane_arbiter import dual_lane_pkg::*; (
   input  logic                 clk,
   input  logic                 reset,
   input  logic [`WORD_W-1:0]   fifo_word_i,
   input  logic                 fifo_empty_i,
   input  logic                 fifo_nearly_full_i,
   input  logic                 in_wr_i,
   output logic                 fifo_wr_o,
   output logic                 fifo_rd_o,
   output logic                 in_rdy_o,
   output logic [`WORD_W-1:0]   lane_word_o,
   input  lane_state_e          lane0_state_i,
   input  lane_state_e          lane1_state_i,
   input  logic                 lane0_rd_i,
   input  logic                 lane1_rd_i,
   output logic                 lane0_valid_o,
   output logic                 lane1_valid_o,
   output logic                 lane0_read_grant_o,
   output logic                 lane1_read_grant_o,
   input  logic                 lane0_wr_i,
   input  logic                 lane1_wr_i,
   input  logic [`WORD_W-1:0]   lane0_word_i,
   input  logic [`WORD_W-1:0]   lane1_word_i,
   output logic                 out_wr_o,
   output logic [`WORD_W-1:0]   out_word_o
);

   lane_sel_e writer_q, writer_d;
   lane_sel_e reader_q, reader_d;
   logic      lane0_wphase, lane1_wphase;
   logic      lane0_writing, lane1_writing;
   logic      lane0_writing_q, lane1_writing_q;
   logic      lane0_reading, lane1_reading;
   logic      lane0_reading_q, lane1_reading_q;
   logic      writer_done, reader_done;
   logic      writer_active;

   // hand over on a finished phase, or when the holder is idle in the
   // wrong phase and the other lane is ready to take over
   function automatic lane_sel_e next_grant(lane_sel_e cur, logic done,
         logic l0_phase, logic l1_phase, logic l0_join, logic l1_join);
      lane_sel_e nxt;
      nxt = cur;
      if (done) begin
         nxt = (cur == SEL_LANE0) ? SEL_LANE1 : SEL_LANE0;
      end else if (cur == SEL_LANE0 && !l0_phase && l1_join) begin
         nxt = SEL_LANE1;
      end else if (cur == SEL_LANE1 && !l1_phase && l0_join) begin
         nxt = SEL_LANE0;
      end
      return nxt;
   endfunction

   assign lane0_wphase  = (lane0_state_i == LANE_START) || (lane0_state_i == LANE_PAYLOAD);
   assign lane1_wphase  = (lane1_state_i == LANE_START) || (lane1_state_i == LANE_PAYLOAD);
   assign lane0_writing = (writer_q == SEL_LANE0) && lane0_wphase;
   assign lane1_writing = (writer_q == SEL_LANE1) && lane1_wphase;
   assign lane0_reading = (reader_q == SEL_LANE0) && (lane0_state_i == LANE_READ_READY);
   assign lane1_reading = (reader_q == SEL_LANE1) && (lane1_state_i == LANE_READ_READY);

   // falling edge of the holder's phase flag
   assign writer_done = (lane0_writing_q && !lane0_writing) ||
                        (lane1_writing_q && !lane1_writing);
   assign reader_done = (lane0_reading_q && !lane0_reading) ||
                        (lane1_reading_q && !lane1_reading);

   assign writer_d = next_grant(writer_q, writer_done, lane0_wphase, lane1_wphase,
                                lane0_state_i == LANE_START, lane1_state_i == LANE_START);
   assign reader_d = next_grant(reader_q, reader_done,
                                lane0_state_i == LANE_READ_READY,
                                lane1_state_i == LANE_READ_READY,
                                lane0_state_i == LANE_READ_READY,
                                lane1_state_i == LANE_READ_READY);

   always_ff @(posedge clk) begin
      if (reset) begin
         writer_q        <= SEL_LANE0;
         reader_q        <= SEL_LANE0;
         lane0_writing_q <= 1'b0;
         lane1_writing_q <= 1'b0;
         lane0_reading_q <= 1'b0;
         lane1_reading_q <= 1'b0;
      end else begin
         writer_q        <= writer_d;
         reader_q        <= reader_d;
         lane0_writing_q <= lane0_writing;
         lane1_writing_q <= lane1_writing;
         lane0_reading_q <= lane0_reading;
         lane1_reading_q <= lane1_reading;
      end
   end

   // input side follows the writer
   assign writer_active = lane0_writing || lane1_writing;
   assign in_rdy_o      = !fifo_nearly_full_i && writer_active;
   assign fifo_wr_o     = in_wr_i && in_rdy_o;
   assign fifo_rd_o     = (writer_q == SEL_LANE0) ? lane0_rd_i : lane1_rd_i;
   assign lane_word_o   = fifo_word_i;
   assign lane0_valid_o = (writer_q == SEL_LANE0) && !fifo_empty_i;
   assign lane1_valid_o = (writer_q == SEL_LANE1) && !fifo_empty_i;

   assign lane0_read_grant_o = (reader_q == SEL_LANE0);
   assign lane1_read_grant_o = (reader_q == SEL_LANE1);

   // output merge
   assign out_wr_o   = lane0_wr_i || lane1_wr_i;
   assign out_word_o = lane1_wr_i ? lane1_word_i : lane0_word_i;

endmodule

//--- verilog/dual_lane_buffer.sv
//////////////////////////////////////////////////////////////////////
// dual-lane store-and-forward buffer, top level; joins the input
// control and data into one word, splits the output word back
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "dual_lane_config.svh"

module dual_lane_buffer import dual_lane_pkg::*; (
   input  logic                 clk,
   input  logic                 reset,
   input  logic [`DATA_W-1:0]   in_data_i,
   input  logic [`CTRL_W-1:0]   in_ctrl_i,
   input  logic                 in_wr_i,
   output logic                 in_rdy_o,
   output logic [`DATA_W-1:0]   out_data_o,
   output logic [`CTRL_W-1:0]   out_ctrl_o,
   output logic                 out_wr_o,
   input  logic                 out_rdy_i
);

   logic [`WORD_W-1:0] fifo_word, head_word, out_word;
   logic [`WORD_W-1:0] lane0_word, lane1_word;
   logic               fifo_wr, fifo_rd, fifo_empty, fifo_nearly_full;
   logic               lane0_valid, lane1_valid, lane0_rd, lane1_rd;
   logic               lane0_grant, lane1_grant, lane0_wr, lane1_wr;
   lane_state_e        lane0_state, lane1_state;

   input_fifo input_fifo_inst (
      .clk(clk), .reset(reset), .din_i({in_ctrl_i, in_data_i}),
      .wr_en_i(fifo_wr), .rd_en_i(fifo_rd), .dout_o(fifo_word),
      .empty_o(fifo_empty), .nearly_full_o(fifo_nearly_full)
   );

   packet_lane lane0_inst (
      .clk(clk), .reset(reset), .word_i(head_word), .fifo_valid_i(lane0_valid),
      .out_rdy_i(out_rdy_i), .read_grant_i(lane0_grant), .fifo_rd_o(lane0_rd),
      .state_o(lane0_state), .lane_wr_o(lane0_wr), .lane_word_o(lane0_word)
   );

   packet_lane lane1_inst (
      .clk(clk), .reset(reset), .word_i(head_word), .fifo_valid_i(lane1_valid),
      .out_rdy_i(out_rdy_i), .read_grant_i(lane1_grant), .fifo_rd_o(lane1_rd),
      .state_o(lane1_state), .lane_wr_o(lane1_wr), .lane_word_o(lane1_word)
   );

   lane_arbiter lane_arbiter_inst (
      .clk(clk), .reset(reset), .fifo_word_i(fifo_word), .fifo_empty_i(fifo_empty),
      .fifo_nearly_full_i(fifo_nearly_full), .in_wr_i(in_wr_i),
      .fifo_wr_o(fifo_wr), .fifo_rd_o(fifo_rd), .in_rdy_o(in_rdy_o),
      .lane_word_o(head_word),
      .lane0_state_i(lane0_state), .lane1_state_i(lane1_state),
      .lane0_rd_i(lane0_rd), .lane1_rd_i(lane1_rd),
      .lane0_valid_o(lane0_valid), .lane1_valid_o(lane1_valid),
      .lane0_read_grant_o(lane0_grant), .lane1_read_grant_o(lane1_grant),
      .lane0_wr_i(lane0_wr), .lane1_wr_i(lane1_wr),
      .lane0_word_i(lane0_word), .lane1_word_i(lane1_word),
      .out_wr_o(out_wr_o), .out_word_o(out_word)
   );

   // control byte on top
   assign {out_ctrl_o, out_data_o} = out_word;

endmodule

//--- verification/tb_clock_gen.sv
//////////////////////////////////////////////////////////////////////
// testbench clock and reset source: 40 ns clock, reset held high for
// the first 5 rising edges
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_clock_gen (
   output logic clk_o,
   output logic reset_o
);

   initial begin
      clk_o = 1'b0;
      forever #20 clk_o = ~clk_o;
   end

   initial begin
      reset_o = 1'b1;
      repeat (5) @(posedge clk_o);
      reset_o <= 1'b0;
   end

endmodule

//--- verification/dual_lane_props.sv
//////////////////////////////////////////////////////////////////////
// concurrent checks on the buffer's top-level ports; bound into
// every dual_lane_buffer instance
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module dual_lane_props (
   input logic clk,
   input logic reset,
   input logic in_rdy_i,
   input logic out_wr_i,
   input logic out_rdy_i
);

   // running failure count, read by the testbench at the end
   int unsigned fail_count = 0;

   // quiet output while in reset
   reset_quiet: assert property (@(posedge clk) reset |=> !out_wr_i)
      else begin
         fail_count++;
         $error("out_wr_o high while reset was applied");
      end

   // and on the first cycle after it
   first_cycle_quiet: assert property (@(posedge clk) $fell(reset) |=> !out_wr_i)
      else begin
         fail_count++;
         $error("out_wr_o high on the first cycle after reset");
      end

   ready_after_reset: assert property (@(posedge clk) $fell(reset) |-> in_rdy_i)
      else begin
         fail_count++;
         $error("in_rdy_o low when reset was released");
      end

   // a stalled downstream gets no word on the next cycle
   backpressure: assert property (@(posedge clk) disable iff (reset)
                                  !out_rdy_i |=> !out_wr_i)
      else begin
         fail_count++;
         $error("out_wr_o high one cycle after out_rdy_i was low");
      end

endmodule

bind dual_lane_buffer dual_lane_props dual_lane_props_inst (
   .clk(clk), .reset(reset), .in_rdy_i(in_rdy_o), .out_wr_i(out_wr_o), .out_rdy_i(out_rdy_i)
);

//--- verification/dual_lane_tb.sv
//////////////////////////////////////////////////////////////////////
// testbench for the dual-lane buffer: random framed packets, gap
// words, output stalls and a fill and drain run, with a scoreboard
// that checks every output word in arrival order
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "dual_lane_config.svh"

module dual_lane_tb;

   localparam int READY_TIMEOUT = 300;
   localparam int DRAIN_TIMEOUT = 4000;
   localparam int FILL_TIMEOUT  = 40;
   // out_rdy_i stall modes
   localparam int RDY_LIGHT = 0;
   localparam int RDY_HEAVY = 1;
   localparam int RDY_LOW   = 2;

   logic               clk, reset, in_wr_i, in_rdy_o, out_wr_o, out_rdy_i;
   logic [`DATA_W-1:0] in_data_i, out_data_o;
   logic [`CTRL_W-1:0] in_ctrl_i, out_ctrl_o;
   logic [`WORD_W:0]   stim_q [$];
   logic [`WORD_W-1:0] exp_q [$];
   integer             seed = 50;
   int                 rdy_mode = RDY_LIGHT;
   int                 errors = 0, tests_run = 0, tests_failed = 0;
   int                 words_out = 0, framed_in = 0;
   int                 errs_mark, out_mark, framed_mark;

   tb_clock_gen clock_gen_inst (.clk_o(clk), .reset_o(reset));

   dual_lane_buffer dual_lane_buffer_inst (
      .clk(clk), .reset(reset), .in_data_i(in_data_i), .in_ctrl_i(in_ctrl_i),
      .in_wr_i(in_wr_i), .in_rdy_o(in_rdy_o), .out_data_o(out_data_o),
      .out_ctrl_o(out_ctrl_o), .out_wr_o(out_wr_o), .out_rdy_i(out_rdy_i)
   );

   // stall pattern rolled on the rising edge, applied on the falling one
   initial begin
      int roll;
      int mode;
      out_rdy_i = 1'b1;
      forever begin
         @(posedge clk);
         roll = $random(seed);
         mode = rdy_mode;
         @(negedge clk);
         out_rdy_i = (mode == RDY_LOW) ? 1'b0 :
                     (mode == RDY_HEAVY) ? roll[0] : (roll[1:0] != 2'b00);
      end
   end

   // scoreboard
   always @(negedge clk) begin
      logic [`WORD_W-1:0] expected;
      if (!reset && out_wr_o) begin
         words_out++;
         assert (exp_q.size() != 0) else begin
            $display("output word at %0t ns with nothing left to expect", $time);
            errors++;
         end
         if (exp_q.size() != 0) begin
            expected = exp_q.pop_front();
            assert (out_ctrl_o == expected[`WORD_W-1:`DATA_W]) else begin
               $display("FAIL at %0t ns: out_ctrl_o expected %h actual %h", $time,
                        expected[`WORD_W-1:`DATA_W], out_ctrl_o);
               errors++;
            end
            assert (out_data_o == expected[`DATA_W-1:0]) else begin
               $display("FAIL at %0t ns: out_data_o expected %h actual %h", $time,
                        expected[`DATA_W-1:0], out_data_o);
               errors++;
            end
         end
      end
   end

   // one packet, start and end words with nonzero control, after optional gap words
   task automatic build_packet(input bit with_gap);
      int                 len;
      int                 gaps;
      int                 i;
      int                 r;
      logic [`CTRL_W-1:0] ctrl;
      logic [`DATA_W-1:0] data;
      len  = 2 + ($unsigned($random(seed)) % 15);
      gaps = with_gap ? 1 + ($unsigned($random(seed)) % 3) : 0;
      ctrl = '0;
      for (i = 0; i < gaps; i++) begin
         data = {$random(seed), $random(seed)};
         stim_q.push_back({1'b0, ctrl, data});
      end
      for (i = 0; i < len; i++) begin
         data = {$random(seed), $random(seed)};
         r    = $random(seed);
         ctrl = (i == 0 || i == len - 1) ? r[`CTRL_W-1:0] | 8'h01 : '0;
         stim_q.push_back({1'b1, ctrl, data});
      end
   endtask

   task automatic put_word(input logic [`WORD_W:0] w);
      in_wr_i   = 1'b1;
      in_ctrl_i = w[`WORD_W-1:`DATA_W];
      in_data_i = w[`DATA_W-1:0];
      if (w[`WORD_W]) begin
         exp_q.push_back(w[`WORD_W-1:0]);
         framed_in++;
      end
   endtask

   task automatic send_queued();
      int wait_cycles;
      while (stim_q.size() != 0) begin
         wait_cycles = 0;
         while (!in_rdy_o && wait_cycles < READY_TIMEOUT) begin
            in_wr_i = 1'b0;
            @(negedge clk);
            wait_cycles++;
         end
         assert (in_rdy_o) else begin
            $display("in_rdy_o stayed low too long at %0t ns, %0d words not sent",
                     $time, stim_q.size());
            errors++;
            stim_q.delete();
         end
         if (stim_q.size() != 0) begin
            put_word(stim_q.pop_front());
            @(negedge clk);
         end
      end
      in_wr_i = 1'b0;
   endtask

   // wait for the scoreboard to empty, then check counts and report
   task automatic drain_and_report(input string name);
      int wait_cycles;
      wait_cycles = 0;
      while (exp_q.size() != 0 && wait_cycles < DRAIN_TIMEOUT) begin
         @(negedge clk);
         wait_cycles++;
      end
      assert (exp_q.size() == 0) else begin
         $display("%0d expected words never left the buffer", exp_q.size());
         errors++;
         exp_q.delete();
      end
      assert (words_out - out_mark == framed_in - framed_mark) else begin
         $display("FAIL at %0t ns: output word count expected %0d actual %0d", $time,
                  framed_in - framed_mark, words_out - out_mark);
         errors++;
      end
      tests_run++;
      if (errors != errs_mark) begin
         tests_failed++;
      end
      $display("test %0d %s: %s, %0d words out", tests_run, name,
               (errors == errs_mark) ? "pass" : "FAIL", words_out - out_mark);
   endtask

   task automatic run_batch(input string name, input int count, input bit with_gap,
                            input int mode);
      int n;
      errs_mark   = errors;
      out_mark    = words_out;
      framed_mark = framed_in;
      rdy_mode    = mode;
      for (n = 0; n < count; n++) begin
         build_packet(with_gap);
      end
      send_queued();
      drain_and_report(name);
   endtask

   initial begin
      int          wait_cycles;
      int          n;
      bit          fell;
      int unsigned prop_fails;
      in_data_i = '0;
      in_ctrl_i = '0;
      in_wr_i   = 1'b0;
      wait_cycles = 0;
      do begin
         @(negedge clk);
         wait_cycles++;
      end while ((reset || !in_rdy_o) && wait_cycles < READY_TIMEOUT);
      assert (!reset && in_rdy_o) else begin
         $display("in_rdy_o did not rise after reset");
         errors++;
      end

      run_batch("packet order", 6, 1'b0, RDY_LIGHT);
      run_batch("gap words dropped", 6, 1'b1, RDY_LIGHT);
      run_batch("output stalls", 6, 1'b0, RDY_HEAVY);

      // hold out_rdy_i low until the input FIFO backs up, then drain
      errs_mark   = errors;
      out_mark    = words_out;
      framed_mark = framed_in;
      rdy_mode    = RDY_LOW;
      repeat (2) @(negedge clk);
      for (n = 0; n < 3; n++) begin
         build_packet(1'b0);
      end
      fell        = 1'b0;
      wait_cycles = 0;
      while (!fell && wait_cycles < FILL_TIMEOUT) begin
         if (in_rdy_o && stim_q.size() != 0) begin
            put_word(stim_q.pop_front());
         end else begin
            in_wr_i = 1'b0;
            fell    = !in_rdy_o && (framed_in != framed_mark);
         end
         @(negedge clk);
         wait_cycles++;
      end
      in_wr_i = 1'b0;
      assert (fell) else begin
         $display("in_rdy_o never fell while out_rdy_i was held low");
         errors++;
      end
      rdy_mode = RDY_LIGHT;
      send_queued();
      drain_and_report("fill and drain");

      prop_fails = dual_lane_buffer_inst.dual_lane_props_inst.fail_count;
      $display("tests run %0d, failed %0d, words checked %0d, errors %0d, property failures %0d",
               tests_run, tests_failed, words_out, errors, prop_fails);
      if (errors == 0 && prop_fails == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

//--- verilog.f
+incdir+include
verilog/dual_lane_pkg.sv
verilog/input_fifo.sv
verilog/packet_lane.sv
verilog/lane_arbiter.sv
verilog/dual_lane_buffer.sv
verification/tb_clock_gen.sv
verification/dual_lane_props.sv
verification/dual_lane_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the dual-lane buffer testbench with Verilator, run it, and look
# for the pass line in its output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module dual_lane_tb -f verilog.f \
   || { echo "verilator build failed"; exit 1; }
sim_out=$(./obj_dir/Vdual_lane_tb +verilator+error+limit+100 2>&1)
echo "$sim_out"
echo "$sim_out" | grep -qxF "Finished with no errors" \
   && { echo "simulation passed"; exit 0; } \
   || { echo "simulation did not pass"; exit 1; }
